// File: verilog/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and instruction width
`define WORD_W 16

// register file
`define REG_AW 3
`define REG_COUNT 8

// instruction memory, one word per entry
`define IMEM_AW 8
`define IMEM_DEPTH 256

// loader bus widths
`define AXI_AW 32
`define AXI_DW 32

`endif

// File: verilog/cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`REG_AW-1:0] reg_addr_t;
	typedef logic [`IMEM_AW-1:0] imem_addr_t;

	// bits 15..11 of an instruction
	typedef logic [4:0] opcode_t;

	localparam opcode_t OP_LI    = 5'b01101;
	localparam opcode_t OP_ADDIU = 5'b01001;
	localparam opcode_t OP_BNEZ  = 5'b00101;
	localparam opcode_t OP_B     = 5'b00010;
	localparam opcode_t OP_RRR   = 5'b11100;
	localparam opcode_t OP_LOGIC = 5'b11101;
	localparam opcode_t OP_NOP   = 5'b00001;

	// function fields
	localparam logic [1:0] FN_ADDU = 2'b01;
	localparam logic [1:0] FN_SUBU = 2'b11;
	localparam logic [4:0] FN_AND  = 5'b01100;
	localparam logic [4:0] FN_OR   = 5'b01101;

	localparam logic [1:0] RESP_OKAY = 2'b00;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_PASS_B
	} alu_op_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		word_t inst;
	} if_id_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		alu_op_t alu_op;
		word_t op_a;
		word_t op_b;
		logic reg_write;
		reg_addr_t dst;
		logic is_bnez;
		logic is_b;
		word_t offset;
	} id_exe_t;

	typedef struct packed {
		logic valid;
		reg_addr_t dst;
		word_t value;
	} commit_t;

	typedef enum logic {
		LD_IDLE,
		LD_RESP
	} loader_state_t;

endpackage

// File: verilog/inst_loader.sv
`include "cpu_defines.svh"

module inst_loader(
	input logic clk,
	input logic rst_n,
	input logic awvalid,
	output logic awready,
	input logic [`AXI_AW-1:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [`AXI_DW-1:0] wdata,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input cpu_pkg::imem_addr_t fetch_addr,
	output cpu_pkg::word_t fetch_inst
);
	import cpu_pkg::*;

	word_t imem [`IMEM_DEPTH];

	loader_state_t state;
	logic have_addr;
	logic have_data;
	imem_addr_t addr_q;
	word_t data_q;

	logic aw_fire;
	logic w_fire;
	logic got_addr;
	logic got_data;
	logic wr_en;
	imem_addr_t wr_addr;
	word_t wr_data;

	assign aw_fire = awvalid && awready;
	assign w_fire = wvalid && wready;
	assign got_addr = have_addr || aw_fire;
	assign got_data = have_data || w_fire;
	assign wr_en = (state == LD_IDLE) && got_addr && got_data;

	// take whichever beat arrives this cycle, else the latched one
	assign wr_addr = aw_fire ? awaddr[`IMEM_AW:1] : addr_q;
	assign wr_data = w_fire ? wdata[`WORD_W-1:0] : data_q;

	assign bresp = RESP_OKAY;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= LD_IDLE;
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			have_addr <= 1'b0;
			have_data <= 1'b0;
		end else begin
			case (state)
				LD_IDLE: begin
					if (aw_fire)
						have_addr <= 1'b1;
					if (w_fire)
						have_data <= 1'b1;
					if (wr_en) begin
						state <= LD_RESP;
						bvalid <= 1'b1;
						awready <= 1'b0;
						wready <= 1'b0;
					end else begin
						awready <= !got_addr;
						wready <= !got_data;
					end
				end
				LD_RESP: begin
					// wait for the master to take the response
					if (bready) begin
						state <= LD_IDLE;
						bvalid <= 1'b0;
						awready <= 1'b1;
						wready <= 1'b1;
						have_addr <= 1'b0;
						have_data <= 1'b0;
					end
				end
				default: state <= LD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (aw_fire)
			addr_q <= awaddr[`IMEM_AW:1];
		if (w_fire)
			data_q <= wdata[`WORD_W-1:0];
		if (wr_en)
			imem[wr_addr] <= wr_data;
	end

	// fetch port, same cycle
	assign fetch_inst = imem[fetch_addr];

	a_bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid);

endmodule

// File: verilog/fetch_stage.sv
`include "cpu_defines.svh"

module fetch_stage(
	input logic clk,
	input logic rst_n,
	input logic run,
	input logic hold,
	input logic redirect,
	input cpu_pkg::word_t redirect_pc,
	output cpu_pkg::imem_addr_t fetch_addr,
	input cpu_pkg::word_t fetch_inst,
	output cpu_pkg::if_id_t if_id
);
	import cpu_pkg::*;

	word_t pc;

	assign fetch_addr = pc[`IMEM_AW-1:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
			if_id <= '0;
		end else if (!run) begin
			// core parked at address 0
			pc <= '0;
			if_id <= '0;
		end else if (redirect) begin
			pc <= redirect_pc;
			if_id.valid <= 1'b0;
		end else if (!hold) begin
			pc <= pc + 1'b1;
			if_id <= '{valid: 1'b1, pc: pc, inst: fetch_inst};
		end
	end

	// a stall never meets a taken branch, so no redirect is lost
	a_no_hold_on_redirect: assert property (@(posedge clk) disable iff (!rst_n)
		redirect |-> !hold);

endmodule

// File: verilog/decode_stage.sv
`include "cpu_defines.svh"

module decode_stage(
	input logic clk,
	input logic rst_n,
	input cpu_pkg::if_id_t if_id,
	output cpu_pkg::reg_addr_t rd_addr_a,
	output cpu_pkg::reg_addr_t rd_addr_b,
	input cpu_pkg::word_t rd_data_a,
	input cpu_pkg::word_t rd_data_b,
	input cpu_pkg::reg_addr_t exe_dst,
	input logic exe_reg_write,
	input logic redirect,
	output logic hold,
	output cpu_pkg::id_exe_t id_exe
);
	import cpu_pkg::*;

	opcode_t opcode;
	reg_addr_t rx;
	reg_addr_t ry;
	reg_addr_t rz;
	word_t imm8_zext;
	word_t imm8_sext;
	word_t imm11_sext;
	logic uses_a;
	logic uses_b;
	id_exe_t id_exe_d;

	// instruction fields
	assign opcode = if_id.inst[15:11];
	assign rx = if_id.inst[10:8];
	assign ry = if_id.inst[7:5];
	assign rz = if_id.inst[4:2];
	assign imm8_zext = {{(`WORD_W-8){1'b0}}, if_id.inst[7:0]};
	assign imm8_sext = {{(`WORD_W-8){if_id.inst[7]}}, if_id.inst[7:0]};
	assign imm11_sext = {{(`WORD_W-11){if_id.inst[10]}}, if_id.inst[10:0]};

	assign rd_addr_a = rx;
	assign rd_addr_b = ry;

	always_comb begin
		id_exe_d = '0;
		id_exe_d.pc = if_id.pc;
		id_exe_d.alu_op = ALU_PASS_B;
		id_exe_d.op_a = rd_data_a;
		id_exe_d.op_b = rd_data_b;
		id_exe_d.dst = rx;
		uses_a = 1'b0;
		uses_b = 1'b0;
		case (opcode)
			OP_LI: begin
				id_exe_d.op_b = imm8_zext;
				id_exe_d.reg_write = 1'b1;
			end
			OP_ADDIU: begin
				id_exe_d.alu_op = ALU_ADD;
				id_exe_d.op_b = imm8_sext;
				id_exe_d.reg_write = 1'b1;
				uses_a = 1'b1;
			end
			OP_BNEZ: begin
				id_exe_d.is_bnez = 1'b1;
				id_exe_d.offset = imm8_sext;
				uses_a = 1'b1;
			end
			OP_B: begin
				id_exe_d.is_b = 1'b1;
				id_exe_d.offset = imm11_sext;
			end
			OP_RRR: begin
				id_exe_d.dst = rz;
				uses_a = 1'b1;
				uses_b = 1'b1;
				if (if_id.inst[1:0] == FN_ADDU) begin
					id_exe_d.alu_op = ALU_ADD;
					id_exe_d.reg_write = 1'b1;
				end else if (if_id.inst[1:0] == FN_SUBU) begin
					id_exe_d.alu_op = ALU_SUB;
					id_exe_d.reg_write = 1'b1;
				end
			end
			OP_LOGIC: begin
				uses_a = 1'b1;
				uses_b = 1'b1;
				if (if_id.inst[4:0] == FN_AND) begin
					id_exe_d.alu_op = ALU_AND;
					id_exe_d.reg_write = 1'b1;
				end else if (if_id.inst[4:0] == FN_OR) begin
					id_exe_d.alu_op = ALU_OR;
					id_exe_d.reg_write = 1'b1;
				end
			end
			// NOP and unknown codes do nothing
			default: ;
		endcase
	end

	// results in write-back come through the register file, so only execute matters
	assign hold = if_id.valid && exe_reg_write &&
		((uses_a && rd_addr_a == exe_dst) || (uses_b && rd_addr_b == exe_dst));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_exe <= '0;
		end else begin
			id_exe <= id_exe_d;
			id_exe.valid <= if_id.valid && !hold && !redirect;
		end
	end

	// one bubble clears the hazard
	a_hold_once: assert property (@(posedge clk) disable iff (!rst_n)
		hold |-> if_id.valid ##1 !hold);

endmodule

// File: verilog/reg_file.sv
`include "cpu_defines.svh"

module reg_file(
	input logic clk,
	input logic rst_n,
	input cpu_pkg::reg_addr_t rd_addr_a,
	input cpu_pkg::reg_addr_t rd_addr_b,
	output cpu_pkg::word_t rd_data_a,
	output cpu_pkg::word_t rd_data_b,
	input cpu_pkg::commit_t commit,
	output cpu_pkg::word_t r0_value
);
	import cpu_pkg::*;

	word_t regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (commit.valid) begin
			regs[commit.dst] <= commit.value;
		end
	end

	// write-through so decode sees this cycle's result
	assign rd_data_a = (commit.valid && commit.dst == rd_addr_a) ? commit.value : regs[rd_addr_a];
	assign rd_data_b = (commit.valid && commit.dst == rd_addr_b) ? commit.value : regs[rd_addr_b];

	assign r0_value = regs[0];

endmodule

// File: verilog/execute_stage.sv
module execute_stage(
	input logic clk,
	input logic rst_n,
	input cpu_pkg::id_exe_t id_exe,
	output cpu_pkg::reg_addr_t exe_dst,
	output logic exe_reg_write,
	output logic redirect,
	output cpu_pkg::word_t redirect_pc,
	output cpu_pkg::commit_t commit
);
	import cpu_pkg::*;

	word_t alu_result;
	logic rx_nonzero;

	always_comb begin
		case (id_exe.alu_op)
			ALU_ADD: alu_result = id_exe.op_a + id_exe.op_b;
			ALU_SUB: alu_result = id_exe.op_a - id_exe.op_b;
			ALU_AND: alu_result = id_exe.op_a & id_exe.op_b;
			ALU_OR: alu_result = id_exe.op_a | id_exe.op_b;
			ALU_PASS_B: alu_result = id_exe.op_b;
			default: alu_result = '0;
		endcase
	end

	// seen by the hazard check in decode
	assign exe_dst = id_exe.dst;
	assign exe_reg_write = id_exe.valid && id_exe.reg_write;

	// branch resolution, no delay slot
	assign rx_nonzero = (id_exe.op_a != '0);
	assign redirect = id_exe.valid && (id_exe.is_b || (id_exe.is_bnez && rx_nonzero));
	assign redirect_pc = id_exe.pc + 1'b1 + id_exe.offset;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			commit <= '0;
		end else begin
			commit.valid <= exe_reg_write;
			commit.dst <= id_exe.dst;
			commit.value <= alu_result;
		end
	end

endmodule

// File: verilog/seg7_decoder.sv
module seg7_decoder(
	input logic [3:0] digit,
	output logic [6:0] segments
);

	// active high, segment a in bit 0 through g in bit 6
	always_comb begin
		case (digit)
			4'h0: segments = 7'h3f;
			4'h1: segments = 7'h06;
			4'h2: segments = 7'h5b;
			4'h3: segments = 7'h4f;
			4'h4: segments = 7'h66;
			4'h5: segments = 7'h6d;
			4'h6: segments = 7'h7d;
			4'h7: segments = 7'h07;
			4'h8: segments = 7'h7f;
			4'h9: segments = 7'h6f;
			4'ha: segments = 7'h77;
			4'hb: segments = 7'h7c;
			4'hc: segments = 7'h39;
			4'hd: segments = 7'h5e;
			4'he: segments = 7'h79;
			default: segments = 7'h71;
		endcase
	end

endmodule

// File: verilog/zhxpu_top.sv
`include "cpu_defines.svh"

module zhxpu_top(
	input logic clk,
	input logic rst_n,
	input logic run,
	input logic awvalid,
	output logic awready,
	input logic [`AXI_AW-1:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [`AXI_DW-1:0] wdata,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	output cpu_pkg::commit_t commit,
	output logic [6:0] seg1,
	output logic [6:0] seg2,
	output logic [15:0] led
);
	import cpu_pkg::*;

	imem_addr_t fetch_addr;
	word_t fetch_inst;
	if_id_t if_id;
	id_exe_t id_exe;
	logic hold;
	logic redirect;
	word_t redirect_pc;
	reg_addr_t rd_addr_a;
	reg_addr_t rd_addr_b;
	word_t rd_data_a;
	word_t rd_data_b;
	reg_addr_t exe_dst;
	logic exe_reg_write;
	word_t r0_value;

	inst_loader __inst_loader(
		.clk(clk),
		.rst_n(rst_n),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wready(wready),
		.wdata(wdata),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.fetch_addr(fetch_addr),
		.fetch_inst(fetch_inst)
	);

	fetch_stage __fetch_stage(
		.clk(clk),
		.rst_n(rst_n),
		.run(run),
		.hold(hold),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.fetch_addr(fetch_addr),
		.fetch_inst(fetch_inst),
		.if_id(if_id)
	);

	decode_stage __decode_stage(
		.clk(clk),
		.rst_n(rst_n),
		.if_id(if_id),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.exe_dst(exe_dst),
		.exe_reg_write(exe_reg_write),
		.redirect(redirect),
		.hold(hold),
		.id_exe(id_exe)
	);

	reg_file __reg_file(
		.clk(clk),
		.rst_n(rst_n),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.commit(commit),
		.r0_value(r0_value)
	);

	execute_stage __execute_stage(
		.clk(clk),
		.rst_n(rst_n),
		.id_exe(id_exe),
		.exe_dst(exe_dst),
		.exe_reg_write(exe_reg_write),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.commit(commit)
	);

	// low byte of r0 on the two digits
	seg7_decoder __seg7_hi(
		.digit(r0_value[7:4]),
		.segments(seg1)
	);
	seg7_decoder __seg7_lo(
		.digit(r0_value[3:0]),
		.segments(seg2)
	);

	// write-back trace
	assign led = {commit.dst, commit.valid, commit.value[11:0]};

endmodule

// File: sim/cpu_ref_model.svh
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

localparam int PROG_WORDS = 41;
localparam int HALT_PC = PROG_WORDS - 1;
localparam logic [15:0] LFSR_SEED = 16'd63;
// x^16 + x^14 + x^13 + x^11 + 1, right shifting
localparam logic [15:0] LFSR_TAPS = 16'hb400;

logic [15:0] lfsr_state;
word_t program_words [PROG_WORDS];
reg_addr_t exp_dst [$];
word_t exp_value [$];

function automatic logic [15:0] lfsr_next(input logic [15:0] state);
	if (state[0])
		return (state >> 1) ^ LFSR_TAPS;
	return state >> 1;
endfunction

// one step per bit
function automatic int unsigned take_bits(input int n);
	int unsigned value;
	value = 0;
	for (int i = 0; i < n; i++) begin
		value = (value << 1) | 32'(lfsr_state[0]);
		lfsr_state = lfsr_next(lfsr_state);
	end
	return value;
endfunction

function automatic void gen_program();
	int unsigned kind;
	reg_addr_t rx;
	reg_addr_t ry;
	reg_addr_t rz;
	logic [7:0] imm;
	int off;
	lfsr_state = LFSR_SEED;
	// dependent chain, each result read by the very next instruction
	program_words[0] = {OP_LI, 3'd1, 8'h05};
	program_words[1] = {OP_ADDIU, 3'd1, 8'h03};
	program_words[2] = {OP_RRR, 3'd1, 3'd1, 3'd2, FN_ADDU};
	program_words[3] = {OP_ADDIU, 3'd2, 8'hff};
	program_words[4] = {OP_RRR, 3'd2, 3'd1, 3'd3, FN_SUBU};
	program_words[5] = {OP_RRR, 3'd3, 3'd3, 3'd0, FN_ADDU};
	for (int pc = 6; pc < HALT_PC; pc++) begin
		kind = take_bits(3);
		rx = reg_addr_t'(take_bits(3));
		ry = reg_addr_t'(take_bits(3));
		rz = reg_addr_t'(take_bits(3));
		imm = 8'(take_bits(8));
		case (kind)
			0: program_words[pc] = {OP_LI, rx, imm};
			1: program_words[pc] = {OP_ADDIU, rx, imm};
			2: program_words[pc] = {OP_RRR, rx, ry, rz, FN_ADDU};
			3: program_words[pc] = {OP_RRR, rx, ry, rz, FN_SUBU};
			4: program_words[pc] = {OP_LOGIC, rx, ry, FN_AND};
			5: program_words[pc] = {OP_LOGIC, rx, ry, FN_OR};
			6: program_words[pc] = 16'h0800;
			default: begin
				off = int'(take_bits(2));
				// never jump past the halt word
				if (pc + 1 + off > HALT_PC)
					off = HALT_PC - pc - 1;
				program_words[pc] = {OP_BNEZ, rx, 8'(off)};
			end
		endcase
	end
	// b to itself
	program_words[HALT_PC] = {OP_B, 11'h7ff};
endfunction

function automatic void push_commit(input reg_addr_t dst, input word_t value);
	exp_dst.push_back(dst);
	exp_value.push_back(value);
endfunction

// instruction-set model, returns the final r0
function automatic word_t run_reference();
	word_t regs [`REG_COUNT];
	word_t inst;
	opcode_t op;
	reg_addr_t rx;
	reg_addr_t ry;
	reg_addr_t rz;
	int pc;
	int steps;
	for (int i = 0; i < `REG_COUNT; i++)
		regs[i] = '0;
	exp_dst.delete();
	exp_value.delete();
	pc = 0;
	steps = 0;
	// branches only go forward, so the loop is bounded
	while (pc != HALT_PC && steps < PROG_WORDS) begin
		inst = program_words[pc];
		op = inst[15:11];
		rx = inst[10:8];
		ry = inst[7:5];
		rz = inst[4:2];
		pc = pc + 1;
		steps++;
		case (op)
			OP_LI: begin
				regs[rx] = {8'h00, inst[7:0]};
				push_commit(rx, regs[rx]);
			end
			OP_ADDIU: begin
				regs[rx] = regs[rx] + {{8{inst[7]}}, inst[7:0]};
				push_commit(rx, regs[rx]);
			end
			OP_BNEZ: begin
				if (regs[rx] != '0)
					pc = pc + int'($signed(inst[7:0]));
			end
			OP_B: pc = pc + int'($signed(inst[10:0]));
			OP_RRR: begin
				if (inst[1:0] == 2'b01) begin
					regs[rz] = regs[rx] + regs[ry];
					push_commit(rz, regs[rz]);
				end else if (inst[1:0] == 2'b11) begin
					regs[rz] = regs[rx] - regs[ry];
					push_commit(rz, regs[rz]);
				end
			end
			OP_LOGIC: begin
				if (inst[4:0] == 5'b01100) begin
					regs[rx] = regs[rx] & regs[ry];
					push_commit(rx, regs[rx]);
				end else if (inst[4:0] == 5'b01101) begin
					regs[rx] = regs[rx] | regs[ry];
					push_commit(rx, regs[rx]);
				end
			end
			default: ;
		endcase
	end
	return regs[0];
endfunction

`endif

// File: sim/tb_zhxpu.sv
`include "cpu_defines.svh"

module tb_zhxpu;
	timeunit 1ns;
	timeprecision 1ps;

	import cpu_pkg::*;

	`include "cpu_ref_model.svh"

	localparam int RESET_CYCLES = 3;
	localparam int DRAIN_CYCLES = 20;
	// load about 4 cycles a word, run at most 3 a word, then margin
	localparam int TIMEOUT_CYCLES = 3 * (PROG_WORDS * 4 + PROG_WORDS * 3 + DRAIN_CYCLES);

	logic clk;
	logic rst_n;
	logic run;
	logic awvalid;
	logic awready;
	logic [`AXI_AW-1:0] awaddr;
	logic wvalid;
	logic wready;
	logic [`AXI_DW-1:0] wdata;
	logic bvalid;
	logic bready;
	logic [1:0] bresp;
	commit_t commit;
	logic [6:0] seg1;
	logic [6:0] seg2;
	logic [15:0] led;

	int errors = 0;
	int checks = 0;
	int commits_seen = 0;
	int cycle_count = 0;
	int exp_count = 0;
	word_t exp_r0;

	zhxpu_top UUT(
		.clk(clk),
		.rst_n(rst_n),
		.run(run),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wready(wready),
		.wdata(wdata),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.commit(commit),
		.seg1(seg1),
		.seg2(seg2),
		.led(led)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// segment a in bit 0, active high
	function automatic logic [6:0] seg_pattern(input logic [3:0] digit);
		case (digit)
			4'h0: return 7'h3f;
			4'h1: return 7'h06;
			4'h2: return 7'h5b;
			4'h3: return 7'h4f;
			4'h4: return 7'h66;
			4'h5: return 7'h6d;
			4'h6: return 7'h7d;
			4'h7: return 7'h07;
			4'h8: return 7'h7f;
			4'h9: return 7'h6f;
			4'ha: return 7'h77;
			4'hb: return 7'h7c;
			4'hc: return 7'h39;
			4'hd: return 7'h5e;
			4'he: return 7'h79;
			default: return 7'h71;
		endcase
	endfunction

	task automatic report_totals();
		$display("checks %0d, errors %0d, commits %0d of %0d",
			checks, errors, commits_seen, exp_count);
	endtask

	task automatic check_reset_outputs();
		checks++;
		assert (!commit.valid && !bvalid && !awready && !wready) else begin
			errors++;
			$display("** Error: in reset commit.valid=%h bvalid=%h awready=%h wready=%h, expected 0",
				commit.valid, bvalid, awready, wready);
		end
	endtask

	task automatic write_word(input int idx, input word_t data, input bit addr_first,
		input int bready_delay);
		bit aw_done;
		bit w_done;
		bit aw_fire;
		bit w_fire;
		aw_done = 1'b0;
		w_done = 1'b0;
		awaddr = `AXI_AW'(idx * 2);
		// upper half must be dropped by the loader
		wdata = {~data, data};
		awvalid = 1'b1;
		wvalid = !addr_first;
		while (!(aw_done && w_done)) begin
			aw_fire = awvalid && awready;
			w_fire = wvalid && wready;
			@(negedge clk);
			if (aw_fire) begin
				aw_done = 1'b1;
				awvalid = 1'b0;
			end
			if (w_fire) begin
				w_done = 1'b1;
				wvalid = 1'b0;
			end
			if (aw_done && !w_done)
				wvalid = 1'b1;
		end
		while (!bvalid)
			@(negedge clk);
		checks++;
		assert (bresp == 2'b00) else begin
			errors++;
			$display("** Error: bresp = %h, expected %h (word %0d)", bresp, 2'b00, idx);
		end
		// back-pressure on the response
		repeat (bready_delay) begin
			@(negedge clk);
			checks++;
			assert (bvalid && !awready && !wready) else begin
				errors++;
				$display("** Error: bready low, bvalid=%h awready=%h wready=%h, expected 1 0 0",
					bvalid, awready, wready);
			end
		end
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic check_commit();
		reg_addr_t want_dst;
		word_t want_value;
		logic [15:0] want_led;
		commits_seen++;
		checks += 2;
		assert (run) else begin
			errors++;
			$display("** Error: commit to r%0d while run is low", commit.dst);
		end
		assert (exp_dst.size() > 0) else begin
			errors++;
			$display("** Error: commit %0d to r%0d is more than the model expects",
				commits_seen, commit.dst);
		end
		if (exp_dst.size() > 0) begin
			want_dst = exp_dst.pop_front();
			want_value = exp_value.pop_front();
			want_led = {want_dst, 1'b1, want_value[11:0]};
			checks += 3;
			assert (commit.dst == want_dst) else begin
				errors++;
				$display("** Error: commit.dst = %h, expected %h (commit %0d)",
					commit.dst, want_dst, commits_seen);
			end
			assert (commit.value == want_value) else begin
				errors++;
				$display("** Error: commit.value = %h, expected %h (commit %0d)",
					commit.value, want_value, commits_seen);
			end
			assert (led == want_led) else begin
				errors++;
				$display("** Error: led = %h, expected %h", led, want_led);
			end
		end
	endtask

	task automatic check_display();
		logic [6:0] want_hi;
		logic [6:0] want_lo;
		want_hi = seg_pattern(exp_r0[7:4]);
		want_lo = seg_pattern(exp_r0[3:0]);
		checks += 4;
		assert (commits_seen == exp_count) else begin
			errors++;
			$display("** Error: saw %0d commits at the halt loop, model has %0d",
				commits_seen, exp_count);
		end
		assert (seg1 == want_hi) else begin
			errors++;
			$display("** Error: seg1 = %h, expected %h", seg1, want_hi);
		end
		assert (seg2 == want_lo) else begin
			errors++;
			$display("** Error: seg2 = %h, expected %h", seg2, want_lo);
		end
		// halt loop writes nothing
		assert (!led[12]) else begin
			errors++;
			$display("** Error: led = %h, expected valid bit 0 in the halt loop", led);
		end
	endtask

	always @(negedge clk) begin
		if (rst_n && commit.valid)
			check_commit();
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			report_totals();
			$display("FAIL: see errors above");
			$finish;
		end
	end

	initial begin
		rst_n = 1'b0;
		run = 1'b0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b0;
		gen_program();
		exp_r0 = run_reference();
		exp_count = exp_dst.size();
		repeat (RESET_CYCLES) begin
			@(posedge clk);
			@(negedge clk);
			check_reset_outputs();
		end
		rst_n = 1'b1;
		// mix beat order, stall some responses
		for (int i = 0; i < PROG_WORDS; i++)
			write_word(i, program_words[i], (i % 2) == 1, (i % 5 == 2) ? 3 : 0);
		@(negedge clk);
		run = 1'b1;
		while (commits_seen < exp_count)
			@(negedge clk);
		repeat (DRAIN_CYCLES) @(negedge clk);
		check_display();
		report_totals();
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+verilog
+incdir+sim
verilog/cpu_pkg.sv
verilog/inst_loader.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/reg_file.sv
verilog/execute_stage.sv
verilog/seg7_decoder.sv
verilog/zhxpu_top.sv
sim/tb_zhxpu.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST ?= build.f
TB_TOP ?= tb_zhxpu
RTL_TOP ?= zhxpu_top
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= PASS: all tests
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS ?= $(shell grep '^verilog/.*\.sv$$' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^$(PASS_TEXT)$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+verilog $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
